/* list.f */
src/la32_isa_pkg.sv
src/decode_pkg.sv
src/inst_decoder.sv
src/ifu_dec.sv
src/dec_pipe_reg.sv
src/ifu_dec_top.sv
tb/clk_gen.sv
tb/ifu_dec_checker.sv
tb/ifu_dec_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -f list.f --top-module ifu_dec_tb -o ifu_dec_sim \
   && ./obj_dir/ifu_dec_sim | tee /dev/stderr | grep "PASS: all tests" > /dev/null \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

/* tb/ifu_dec_tb.sv */
`timescale 1ns/1ps

module ifu_dec_tb
   import la32_isa_pkg::*, decode_pkg::*;
();

   // one accepted fetch beat
   typedef struct packed {
      pc_t      pc;
      inst_t    inst;
      logic     fexc;
      exccode_t fcode;
      logic     intx;
   } stim_t;

   // expected decode of one beat
   typedef struct packed {
      dec_op_t  op;
      logic     wen;
      reg_idx_t tgt;
      logic     exc;
      exccode_t code;
   } exp_t;

   logic     clk;
   logic     rst_n;
   logic     fetch_valid;
   logic     fetch_ready;
   pc_t      fetch_pc;
   inst_t    fetch_inst;
   logic     fetch_exception;
   exccode_t fetch_exccode;
   logic     int_except;
   logic     dec_valid;
   logic     dec_ready;
   pc_t      dec_pc;
   inst_t    dec_inst;
   dec_op_t  dec_op;
   logic     dec_rf_wen;
   reg_idx_t dec_rf_target;
   logic     dec_exception;
   exccode_t dec_exccode;

   int    seed = 67061;
   int    ready_seed = 67061;
   int    max_wait = 100;
   int    check_count = 0;
   int    err_count = 0;
   int    timeout_count = 0;
   int    sent = 0;
   int    received = 0;
   logic  bp_on;
   logic  stream_mode;
   logic  loaded;
   pc_t   loaded_pc;
   pc_t   next_pc;
   stim_t exp_q[$];

   clk_gen u_clk_gen (
      .clk (clk)
   );

   ifu_dec_top dut (
      .clk             (clk),
      .rst_n           (rst_n),
      .fetch_valid     (fetch_valid),
      .fetch_ready     (fetch_ready),
      .fetch_pc        (fetch_pc),
      .fetch_inst      (fetch_inst),
      .fetch_exception (fetch_exception),
      .fetch_exccode   (fetch_exccode),
      .int_except      (int_except),
      .dec_valid       (dec_valid),
      .dec_ready       (dec_ready),
      .dec_pc          (dec_pc),
      .dec_inst        (dec_inst),
      .dec_op          (dec_op),
      .dec_rf_wen      (dec_rf_wen),
      .dec_rf_target   (dec_rf_target),
      .dec_exception   (dec_exception),
      .dec_exccode     (dec_exccode)
   );

   bind ifu_dec_top ifu_dec_checker u_checker (
      .clk           (clk),
      .rst_n         (rst_n),
      .dec_valid     (dec_valid),
      .dec_ready     (dec_ready),
      .dec_pc        (dec_pc),
      .dec_inst      (dec_inst),
      .dec_op        (dec_op),
      .dec_rf_wen    (dec_rf_wen),
      .dec_rf_target (dec_rf_target),
      .dec_exception (dec_exception),
      .dec_exccode   (dec_exccode)
   );

   function automatic logic [31:0] rand32();
      rand32 = $random(seed);
   endfunction

   // expected decode straight from the isa rules
   function automatic exp_t ref_decode(input inst_t inst, input logic fexc,
                                       input exccode_t fcode, input logic intx);
      exp_t      e;
      dec_op_t   op;
      alu_code_t alu;
      bru_code_t bru;
      op  = '0;
      alu = ALU_NONE;
      bru = BRU_NONE;
      if (inst[31:15] == OPC_ADD_W)
         alu = ALU_ADD;
      else if (inst[31:15] == OPC_SUB_W)
         alu = ALU_SUB;
      else if (inst[31:15] == OPC_AND)
         alu = ALU_AND;
      else if (inst[31:15] == OPC_OR)
         alu = ALU_OR;
      else if (inst[31:15] == OPC_XOR)
         alu = ALU_XOR;
      else if (inst[31:15] == OPC_SYSCALL)
         op[SYSCALL] = 1'b1;
      else if (inst[31:15] == OPC_BREAK)
         op[BREAK] = 1'b1;
      else if (inst[31:22] == OPC_ADDI_W) begin
         alu          = ALU_ADD;
         op[IMM_USED] = 1'b1;
      end
      else if (inst[31:22] == OPC_LD_W)
         op[LSU_RELATED] = 1'b1;
      else if (inst[31:22] == OPC_ST_W)
         op[LSU_STORE] = 1'b1;
      else if (inst[31:26] == OPC_JIRL)
         bru = BRU_JIRL;
      else if (inst[31:26] == OPC_B)
         bru = BRU_B;
      else if (inst[31:26] == OPC_BL)
         bru = BRU_BL;
      else if (inst[31:26] == OPC_BEQ)
         bru = BRU_BEQ;
      else if (inst[31:26] == OPC_BNE)
         bru = BRU_BNE;
      else
         op[INE] = 1'b1;
      // a store is still a memory op
      if (op[LSU_STORE])
         op[LSU_RELATED] = 1'b1;
      // memory ops and branches carry an immediate
      if (op[LSU_RELATED] || bru != BRU_NONE)
         op[IMM_USED] = 1'b1;
      op[ALU_RELATED] = alu != ALU_NONE;
      op[BRU_RELATED] = bru != BRU_NONE;
      op[ALU_CODE_MSB:ALU_CODE_LSB] = alu;
      op[BRU_CODE_MSB:BRU_CODE_LSB] = bru;
      // writers: alu ops, loads, jirl, bl
      op[GR_WEN] = op[ALU_RELATED] || (op[LSU_RELATED] && !op[LSU_STORE]) ||
                   bru == BRU_JIRL || bru == BRU_BL;
      e.op  = op;
      e.wen = op[GR_WEN];
      e.tgt = !e.wen ? 5'd0 : (bru == BRU_BL) ? 5'd1 : inst[4:0];
      e.exc = intx || fexc || op[SYSCALL] || op[BREAK] || op[INE];
      e.code = intx ? EXC_INT : fexc ? fcode : op[SYSCALL] ? EXC_SYS :
               op[BREAK] ? EXC_BRK : op[INE] ? EXC_INE : 6'd0;
      return e;
   endfunction

   // kinds 0..14 follow the opcode table, anything else is an illegal word
   function automatic inst_t make_inst(input int kind);
      logic [31:0] r;
      inst_t       w;
      exp_t        e;
      r = rand32();
      case (kind)
         0:  w = {OPC_ADD_W, r[14:0]};
         1:  w = {OPC_SUB_W, r[14:0]};
         2:  w = {OPC_AND, r[14:0]};
         3:  w = {OPC_OR, r[14:0]};
         4:  w = {OPC_XOR, r[14:0]};
         5:  w = {OPC_SYSCALL, r[14:0]};
         6:  w = {OPC_BREAK, r[14:0]};
         7:  w = {OPC_ADDI_W, r[21:0]};
         8:  w = {OPC_LD_W, r[21:0]};
         9:  w = {OPC_ST_W, r[21:0]};
         10: w = {OPC_JIRL, r[25:0]};
         11: w = {OPC_B, r[25:0]};
         12: w = {OPC_BL, r[25:0]};
         13: w = {OPC_BEQ, r[25:0]};
         14: w = {OPC_BNE, r[25:0]};
         default: begin
            // redraw until no opcode matches
            w = r;
            e = ref_decode(w, 1'b0, 6'd0, 1'b0);
            for (int i = 0; i < 64 && !e.op[INE]; i++) begin
               w = rand32();
               e = ref_decode(w, 1'b0, 6'd0, 1'b0);
            end
         end
      endcase
      return w;
   endfunction

   task automatic check_op(input string name, input dec_op_t got, input dec_op_t want);
      check_count++;
      if (got !== want) begin
         err_count++;
         $display("CHECK FAILED t=%0t %s got %h exp %h", $time, name, got, want);
      end
   endtask

   task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t want);
      check_count++;
      if (got !== want) begin
         err_count++;
         $display("CHECK FAILED t=%0t %s got %0d exp %0d", $time, name, got, want);
      end
   endtask

   task automatic check_code(input string name, input exccode_t got, input exccode_t want);
      check_count++;
      if (got !== want) begin
         err_count++;
         $display("CHECK FAILED t=%0t %s got %h exp %h", $time, name, got, want);
      end
   endtask

   task automatic check_pc(input string name, input pc_t got, input pc_t want);
      check_count++;
      if (got !== want) begin
         err_count++;
         $display("CHECK FAILED t=%0t %s got %h exp %h", $time, name, got, want);
      end
   endtask

   task automatic check_inst(input string name, input inst_t got, input inst_t want);
      check_count++;
      if (got !== want) begin
         err_count++;
         $display("CHECK FAILED t=%0t %s got %h exp %h", $time, name, got, want);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic want);
      check_count++;
      if (got !== want) begin
         err_count++;
         $display("CHECK FAILED t=%0t %s got %b exp %b", $time, name, got, want);
      end
   endtask

   // called at a falling edge, returns at the falling edge after acceptance
   task automatic send_inst(input int kind, input logic fexc, input logic intx);
      logic [31:0] r;
      logic        taken;
      int          waited;
      if (timeout_count != 0)
         return;
      r = rand32();
      fetch_valid     = 1'b1;
      fetch_pc        = next_pc;
      fetch_inst      = make_inst(kind);
      fetch_exception = fexc;
      // random code, only used when fexc is set
      fetch_exccode   = r[5:0];
      int_except      = intx;
      next_pc         = next_pc + 32'd4;
      taken  = 1'b0;
      waited = 0;
      while (!taken && waited < max_wait) begin
         @(posedge clk);
         taken  = fetch_ready;
         waited = waited + 1;
      end
      if (!taken) begin
         $display("timeout: instruction at pc %h was never accepted", fetch_pc);
         timeout_count++;
      end
      @(negedge clk);
   endtask

   task automatic idle_cycle();
      logic [31:0] r;
      r = rand32();
      fetch_valid = 1'b0;
      // junk on the bus while invalid
      fetch_inst  = r;
      @(negedge clk);
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < max_wait) begin
         @(posedge clk);
         waited = waited + 1;
      end
      if (exp_q.size() != 0 && timeout_count == 0) begin
         $display("timeout: %0d results never left the decode stage", exp_q.size());
         timeout_count++;
      end
   endtask

   // random stall on the execute side
   always @(negedge clk) begin
      logic [31:0] r;
      if (bp_on) begin
         r = $random(ready_seed);
         dec_ready = r[0];
      end
      else
         dec_ready = 1'b1;
   end

   // scoreboard, all sampling on the rising edge
   always @(posedge clk) begin
      stim_t s;
      exp_t  e;
      if (!rst_n)
         loaded = 1'b0;
      else begin
         // a beat taken last edge must show up now
         if (loaded) begin
            check_bit("dec_valid", dec_valid, 1'b1);
            check_pc("dec_pc", dec_pc, loaded_pc);
         end
         // no stall allowed while dec_ready stays high
         if (stream_mode && fetch_valid)
            check_bit("fetch_ready", fetch_ready, 1'b1);
         if (dec_valid && dec_ready) begin
            if (exp_q.size() == 0) begin
               err_count++;
               $display("result with pc %h came out with nothing pending at t=%0t",
                        dec_pc, $time);
            end
            else begin
               s = exp_q.pop_front();
               e = ref_decode(s.inst, s.fexc, s.fcode, s.intx);
               received++;
               check_pc("dec_pc", dec_pc, s.pc);
               check_inst("dec_inst", dec_inst, s.inst);
               check_op("dec_op", dec_op, e.op);
               check_bit("dec_rf_wen", dec_rf_wen, e.wen);
               check_reg("dec_rf_target", dec_rf_target, e.tgt);
               check_bit("dec_exception", dec_exception, e.exc);
               check_code("dec_exccode", dec_exccode, e.code);
            end
         end
         if (fetch_valid && fetch_ready) begin
            s.pc    = fetch_pc;
            s.inst  = fetch_inst;
            s.fexc  = fetch_exception;
            s.fcode = fetch_exccode;
            s.intx  = int_except;
            exp_q.push_back(s);
            sent++;
            loaded    = 1'b1;
            loaded_pc = fetch_pc;
         end
         else
            loaded = 1'b0;
      end
   end

   initial begin
      logic [31:0] r;
      rst_n           = 1'b0;
      fetch_valid     = 1'b0;
      fetch_pc        = '0;
      fetch_inst      = '0;
      fetch_exception = 1'b0;
      fetch_exccode   = '0;
      int_except      = 1'b0;
      dec_ready       = 1'b1;
      bp_on           = 1'b0;
      stream_mode     = 1'b0;
      loaded          = 1'b0;
      loaded_pc       = '0;
      next_pc         = 32'h1c00_0000;
      for (int i = 0; i < 10; i++)
         @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      // empty and open right after reset
      check_bit("dec_valid", dec_valid, 1'b0);
      check_bit("fetch_ready", fetch_ready, 1'b1);

      // every known opcode, back to back
      stream_mode = 1'b1;
      for (int k = 0; k < 15; k++) begin
         for (int n = 0; n < 4; n++)
            send_inst(k, 1'b0, 1'b0);
      end
      // words outside the subset
      for (int n = 0; n < 40; n++)
         send_inst(15, 1'b0, 1'b0);
      // fetch side code wins over sys, brk and ine
      for (int n = 0; n < 32; n++)
         send_inst(n % 16, 1'b1, 1'b0);
      // interrupt wins over all of it
      for (int n = 0; n < 32; n++)
         send_inst(n % 16, n[0], 1'b1);
      stream_mode = 1'b0;
      idle_cycle();

      // mixed traffic with gaps and random stalls
      bp_on = 1'b1;
      for (int n = 0; n < 200; n++) begin
         r = rand32();
         send_inst(int'(r[3:0]), r[7:4] == 4'd0, r[11:8] == 4'd0);
         if (r[12] && r[13])
            idle_cycle();
      end
      idle_cycle();
      bp_on = 1'b0;
      wait_drain();

      if (sent != received) begin
         err_count++;
         $display("%0d instructions went in but %0d results came out", sent, received);
      end
      $display("checks %0d  errors %0d  timeouts %0d  sent %0d  received %0d",
               check_count, err_count, timeout_count, sent, received);
      if (err_count == 0 && timeout_count == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

/* tb/ifu_dec_checker.sv */
`timescale 1ns/1ps

module ifu_dec_checker
   import la32_isa_pkg::*, decode_pkg::*;
(
   input logic     clk,
   input logic     rst_n,
   input logic     dec_valid,
   input logic     dec_ready,
   input pc_t      dec_pc,
   input inst_t    dec_inst,
   input dec_op_t  dec_op,
   input logic     dec_rf_wen,
   input reg_idx_t dec_rf_target,
   input logic     dec_exception,
   input exccode_t dec_exccode
);

   // stage comes out of reset empty
   a_empty_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !dec_valid)
      else $error("dec_valid high in the first cycle after reset");

   // stalled result must not move
   a_hold_when_stalled: assert property (@(posedge clk) disable iff (!rst_n)
      dec_valid && !dec_ready |=> dec_valid && $stable(dec_pc) && $stable(dec_inst) &&
      $stable(dec_op) && $stable(dec_rf_wen) && $stable(dec_rf_target) &&
      $stable(dec_exception) && $stable(dec_exccode))
      else $error("decode outputs changed while stalled by dec_ready");

   // no write means no target
   a_target_zero: assert property (@(posedge clk) disable iff (!rst_n)
      dec_valid && !dec_rf_wen |-> dec_rf_target == '0)
      else $error("dec_rf_target nonzero with dec_rf_wen low");

endmodule

/* tb/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
   output logic clk
);

   // 4 ns period, starts low
   initial clk = 1'b0;

   always #2 clk = ~clk;

endmodule

/* src/ifu_dec_top.sv */
`timescale 1ns/1ps

module ifu_dec_top
   import la32_isa_pkg::*, decode_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   // from fetch
   input  logic     fetch_valid,
   output logic     fetch_ready,
   input  pc_t      fetch_pc,
   input  inst_t    fetch_inst,
   input  logic     fetch_exception,
   input  exccode_t fetch_exccode,
   input  logic     int_except,
   // to execute
   output logic     dec_valid,
   input  logic     dec_ready,
   output pc_t      dec_pc,
   output inst_t    dec_inst,
   output dec_op_t  dec_op,
   output logic     dec_rf_wen,
   output reg_idx_t dec_rf_target,
   output logic     dec_exception,
   output exccode_t dec_exccode
);

   // decode results, same cycle as fetch
   dec_op_t  d_op;
   logic     d_rf_wen;
   reg_idx_t d_rf_target;
   logic     d_exception;
   exccode_t d_exccode;

   ifu_dec u_ifu_dec (
      .clk             (clk),
      .rst_n           (rst_n),
      .inst            (fetch_inst),
      .fetch_exception (fetch_exception),
      .fetch_exccode   (fetch_exccode),
      .int_except      (int_except),
      .op              (d_op),
      .rf_wen          (d_rf_wen),
      .rf_target       (d_rf_target),
      .exception       (d_exception),
      .exccode         (d_exccode)
   );

   // one stage toward execute
   dec_pipe_reg u_dec_pipe_reg (
      .clk           (clk),
      .rst_n         (rst_n),
      .in_valid      (fetch_valid),
      .in_ready      (fetch_ready),
      .in_pc         (fetch_pc),
      .in_inst       (fetch_inst),
      .in_op         (d_op),
      .in_rf_wen     (d_rf_wen),
      .in_rf_target  (d_rf_target),
      .in_exception  (d_exception),
      .in_exccode    (d_exccode),
      .out_valid     (dec_valid),
      .out_ready     (dec_ready),
      .out_pc        (dec_pc),
      .out_inst      (dec_inst),
      .out_op        (dec_op),
      .out_rf_wen    (dec_rf_wen),
      .out_rf_target (dec_rf_target),
      .out_exception (dec_exception),
      .out_exccode   (dec_exccode)
   );

endmodule

/* src/dec_pipe_reg.sv */
`timescale 1ns/1ps

module dec_pipe_reg
   import la32_isa_pkg::*, decode_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     in_valid,
   output logic     in_ready,
   input  pc_t      in_pc,
   input  inst_t    in_inst,
   input  dec_op_t  in_op,
   input  logic     in_rf_wen,
   input  reg_idx_t in_rf_target,
   input  logic     in_exception,
   input  exccode_t in_exccode,
   output logic     out_valid,
   input  logic     out_ready,
   output pc_t      out_pc,
   output inst_t    out_inst,
   output dec_op_t  out_op,
   output logic     out_rf_wen,
   output reg_idx_t out_rf_target,
   output logic     out_exception,
   output exccode_t out_exccode
);

   logic load;

   // accept when empty or when the slot drains this cycle
   assign in_ready = !out_valid || out_ready;
   assign load     = in_valid && in_ready;

   // slot valid bit
   always_ff @(posedge clk) begin
      if (!rst_n)
         out_valid <= 1'b0;
      else if (load)
         out_valid <= 1'b1;
      else if (out_ready)
         out_valid <= 1'b0;
   end

   // payload only moves on a load, holds under back-pressure
   always_ff @(posedge clk) begin
      if (load) begin
         out_pc        <= in_pc;
         out_inst      <= in_inst;
         out_op        <= in_op;
         out_rf_wen    <= in_rf_wen;
         out_rf_target <= in_rf_target;
         out_exception <= in_exception;
         out_exccode   <= in_exccode;
      end
   end

endmodule

/* src/ifu_dec.sv */
`timescale 1ns/1ps

module ifu_dec
   import la32_isa_pkg::*, decode_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  inst_t    inst,
   input  logic     fetch_exception,
   input  exccode_t fetch_exccode,
   input  logic     int_except,
   output dec_op_t  op,
   output logic     rf_wen,
   output reg_idx_t rf_target,
   output logic     exception,
   output exccode_t exccode
);

   // purely combinational, clk and rst_n only follow the block convention
   dec_op_t  dec_res;
   logic     is_bl;
   reg_idx_t waddr;

   inst_decoder u_inst_decoder (
      .inst (inst),
      .res  (dec_res)
   );

   // bl links into r1, everything else into rd
   assign is_bl = dec_res[BRU_RELATED] &&
                  (dec_res[BRU_CODE_MSB:BRU_CODE_LSB] == BRU_BL);
   assign waddr = is_bl ? reg_idx_t'(1) : inst[RD_MSB:RD_LSB];

   assign op     = dec_res;
   assign rf_wen = dec_res[GR_WEN];
   // no write, no target
   assign rf_target = rf_wen ? waddr : '0;

   // any source raises the flag
   assign exception = int_except || fetch_exception ||
                      dec_res[SYSCALL] || dec_res[BREAK] || dec_res[INE];

   // code priority: int, fetch, sys, brk, ine
   always_comb begin
      if (int_except)
         exccode = EXC_INT;
      else if (fetch_exception)
         exccode = fetch_exccode;
      else if (dec_res[SYSCALL])
         exccode = EXC_SYS;
      else if (dec_res[BREAK])
         exccode = EXC_BRK;
      else if (dec_res[INE])
         exccode = EXC_INE;
      else
         exccode = '0;
   end

endmodule

/* src/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder
   import la32_isa_pkg::*, decode_pkg::*;
(
   input  inst_t   inst,
   output dec_op_t res
);

   // the three opcode field views
   logic [16:0] op17;
   logic [9:0]  op10;
   logic [5:0]  op6;

   // per-category pieces, packed into res below
   logic      wen;
   logic      alu_en;
   alu_code_t alu_code;
   logic      lsu_en;
   logic      lsu_store;
   logic      bru_en;
   bru_code_t bru_code;
   logic      imm;
   logic      sys;
   logic      brk;
   logic      hit;

   assign op17 = inst[31:OPC17_LSB];
   assign op10 = inst[31:OPC10_LSB];
   assign op6  = inst[31:OPC6_LSB];

   always_comb begin
      wen       = 1'b0;
      alu_en    = 1'b0;
      alu_code  = ALU_NONE;
      lsu_en    = 1'b0;
      lsu_store = 1'b0;
      bru_en    = 1'b0;
      bru_code  = BRU_NONE;
      imm       = 1'b0;
      sys       = 1'b0;
      brk       = 1'b0;
      hit       = 1'b1;
      // 3R and system group first
      case (op17)
         OPC_ADD_W:   alu_code = ALU_ADD;
         OPC_SUB_W:   alu_code = ALU_SUB;
         OPC_AND:     alu_code = ALU_AND;
         OPC_OR:      alu_code = ALU_OR;
         OPC_XOR:     alu_code = ALU_XOR;
         OPC_SYSCALL: sys = 1'b1;
         OPC_BREAK:   brk = 1'b1;
         default:     hit = 1'b0;
      endcase
      // 3R ops all write rd
      if (alu_code != ALU_NONE) begin
         alu_en = 1'b1;
         wen    = 1'b1;
      end
      if (!hit) begin
         hit = 1'b1;
         case (op10)
            OPC_ADDI_W: begin
               alu_en   = 1'b1;
               alu_code = ALU_ADD;
               wen      = 1'b1;
            end
            OPC_LD_W: begin
               lsu_en = 1'b1;
               wen    = 1'b1;
            end
            OPC_ST_W: begin
               lsu_en    = 1'b1;
               lsu_store = 1'b1;
            end
            default: hit = 1'b0;
         endcase
         imm = hit;
      end
      if (!hit) begin
         hit = 1'b1;
         case (op6)
            OPC_JIRL: bru_code = BRU_JIRL;
            OPC_B:    bru_code = BRU_B;
            OPC_BL:   bru_code = BRU_BL;
            OPC_BEQ:  bru_code = BRU_BEQ;
            OPC_BNE:  bru_code = BRU_BNE;
            default:  hit = 1'b0;
         endcase
         bru_en = hit;
         imm    = hit;
         // only jirl and bl link
         wen    = (bru_code == BRU_JIRL) || (bru_code == BRU_BL);
      end
   end

   always_comb begin
      res                           = '0;
      res[GR_WEN]                   = wen;
      res[ALU_RELATED]              = alu_en;
      res[ALU_CODE_MSB:ALU_CODE_LSB] = alu_code;
      res[LSU_RELATED]              = lsu_en;
      res[LSU_STORE]                = lsu_store;
      res[BRU_RELATED]              = bru_en;
      res[BRU_CODE_MSB:BRU_CODE_LSB] = bru_code;
      res[IMM_USED]                 = imm;
      res[SYSCALL]                  = sys;
      res[BREAK]                    = brk;
      res[RSVD_MSB:RSVD_LSB]        = '0;
      // unknown encoding flags INE and nothing else
      res[INE]                      = !hit;
   end

endmodule

/* src/decode_pkg.sv */
package decode_pkg;

   // width of the flat decoded-op vector
   localparam int DECODE_RES_BIT = 20;

   typedef logic [DECODE_RES_BIT-1:0] dec_op_t;

   // sub-code widths
   typedef logic [3:0] alu_code_t;
   typedef logic [3:0] bru_code_t;

   // bit positions inside dec_op_t
   localparam int GR_WEN       = 0;
   localparam int ALU_RELATED  = 1;
   localparam int ALU_CODE_LSB = 2;
   localparam int ALU_CODE_MSB = 5;
   localparam int LSU_RELATED  = 6;
   localparam int LSU_STORE    = 7;
   localparam int BRU_RELATED  = 8;
   localparam int BRU_CODE_LSB = 9;
   localparam int BRU_CODE_MSB = 12;
   localparam int IMM_USED     = 13;
   localparam int SYSCALL      = 14;
   localparam int BREAK        = 15;
   localparam int INE          = 16;
   // bits 19:17 reserved, always zero
   localparam int RSVD_LSB     = 17;
   localparam int RSVD_MSB     = 19;

   // alu sub-codes
   // zero means no alu op
   localparam alu_code_t ALU_NONE = 4'd0;
   localparam alu_code_t ALU_ADD  = 4'd1;
   localparam alu_code_t ALU_SUB  = 4'd2;
   localparam alu_code_t ALU_AND  = 4'd3;
   localparam alu_code_t ALU_OR   = 4'd4;
   localparam alu_code_t ALU_XOR  = 4'd5;

   // branch unit sub-codes
   localparam bru_code_t BRU_NONE = 4'd0;
   localparam bru_code_t BRU_JIRL = 4'd1;
   localparam bru_code_t BRU_B    = 4'd2;
   localparam bru_code_t BRU_BL   = 4'd3;
   localparam bru_code_t BRU_BEQ  = 4'd4;
   localparam bru_code_t BRU_BNE  = 4'd5;

endpackage

/* src/la32_isa_pkg.sv */
package la32_isa_pkg;

   // basic widths of the la32 integer subset
   typedef logic [31:0] inst_t;
   typedef logic [31:0] pc_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [5:0]  exccode_t;

   // register fields, same place in every format
   localparam int RD_LSB = 0;
   localparam int RD_MSB = 4;
   localparam int RJ_LSB = 5;
   localparam int RJ_MSB = 9;

   // opcode field widths, all left aligned at bit 31
   localparam int OPC17_LSB = 15;
   localparam int OPC10_LSB = 22;
   localparam int OPC6_LSB  = 26;

   // 3R type and system, opcode in bits 31:15
   localparam logic [16:0] OPC_ADD_W   = 17'h00020;
   localparam logic [16:0] OPC_SUB_W   = 17'h00022;
   localparam logic [16:0] OPC_AND     = 17'h00029;
   localparam logic [16:0] OPC_OR      = 17'h0002A;
   localparam logic [16:0] OPC_XOR     = 17'h0002B;
   localparam logic [16:0] OPC_BREAK   = 17'h00054;
   localparam logic [16:0] OPC_SYSCALL = 17'h00056;

   // 2RI12 type, opcode in bits 31:22
   localparam logic [9:0] OPC_ADDI_W = 10'h00A;
   localparam logic [9:0] OPC_LD_W   = 10'h0A2;
   localparam logic [9:0] OPC_ST_W   = 10'h0A6;

   // branch and jump, opcode in bits 31:26
   localparam logic [5:0] OPC_JIRL = 6'h13;
   localparam logic [5:0] OPC_B    = 6'h14;
   localparam logic [5:0] OPC_BL   = 6'h15;
   localparam logic [5:0] OPC_BEQ  = 6'h16;
   localparam logic [5:0] OPC_BNE  = 6'h17;

   // estat ecode values
   localparam exccode_t EXC_INT = 6'h00;
   localparam exccode_t EXC_SYS = 6'h0B;
   localparam exccode_t EXC_BRK = 6'h0C;
   localparam exccode_t EXC_INE = 6'h0D;

endpackage
